//--- src/cnn_data_pkg.sv
package cnn_data_pkg;

  typedef logic signed [7:0]  pixel_t;
  typedef logic signed [19:0] acc_t;

  localparam int KSIZE      = 3;
  localparam int TAPS       = KSIZE * KSIZE;
  localparam int NUM_FILT   = 2;
  localparam int NUM_LAYERS = 2;
  localparam int ADDR_W     = 16;

  typedef logic [ADDR_W-1:0] addr_t;

  // tap 0 is the top-left of the window, row-major
  typedef pixel_t [TAPS-1:0] patch_t;

  typedef struct packed {
    logic   we;
    addr_t  addr;
    patch_t patch;
  } ram_wr_t;

  // indexed [layer][filter][tap]
  localparam pixel_t WEIGHTS [NUM_LAYERS][NUM_FILT][TAPS] = '{
    '{'{  1,  2,  1,  0,  0,  0, -1, -2, -1 },
      '{ -1,  0,  1, -2,  0,  2, -1,  0,  1 }},
    '{'{  0, -1,  0, -1,  4, -1,  0, -1,  0 },
      '{ 127, -128, 3, 17, -64, 90, -5, 41, -128 }}
  };

  localparam acc_t BIASES [NUM_LAYERS][NUM_FILT] = '{'{ 5, -3 }, '{ 100, -250 }};

endpackage

//--- src/cnn_ctrl_pkg.sv
package cnn_ctrl_pkg;

  // phases of one layer run
  typedef enum logic [2:0] {
    IDLE,
    ZPAD,
    IM2C,
    DOTP,
    BIAS,
    DONE
  } calc_state_t;

  // selects a row of the weight and bias tables
  typedef logic [0:0] layer_t;

endpackage

//--- src/calc_sequencer.sv
`timescale 1ns/1ns

module calc_sequencer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req,
  input  cnn_ctrl_pkg::layer_t layer_sel,
  input  logic                im2c_done,
  input  logic                dot_done,
  output logic                zpad_start,
  output logic                im2c_start,
  output logic                dot_start,
  output logic                bias_start,
  output cnn_ctrl_pkg::layer_t layer,
  output logic                ack
);
  import cnn_ctrl_pkg::*;

  calc_state_t state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      zpad_start <= 1'b0;
      im2c_start <= 1'b0;
      dot_start  <= 1'b0;
      bias_start <= 1'b0;
      layer      <= '0;
      ack        <= 1'b0;
    end else begin
      zpad_start <= 1'b0;
      im2c_start <= 1'b0;
      dot_start  <= 1'b0;
      bias_start <= 1'b0;
      // ack drops on the edge that sees req low
      ack        <= (state == DONE) && req;
      case (state)
        IDLE: if (req) begin
          state      <= ZPAD;
          zpad_start <= 1'b1;
          layer      <= layer_sel;
        end
        ZPAD: begin
          state      <= IM2C;
          im2c_start <= 1'b1;
        end
        IM2C: if (im2c_done) begin
          state     <= DOTP;
          dot_start <= 1'b1;
        end
        DOTP: if (dot_done) begin
          state      <= BIAS;
          bias_start <= 1'b1;
        end
        BIAS: state <= DONE;
        DONE: if (!req) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- src/zero_padding.sv
`timescale 1ns/1ns

module zero_padding #(
  parameter int IMG_H = 3,
  parameter int IMG_W = 4
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          load,
  input  cnn_data_pkg::pixel_t [IMG_H*IMG_W-1:0]         img,
  output cnn_data_pkg::pixel_t [(IMG_H+2)*(IMG_W+2)-1:0] frame
);

  localparam int FW = IMG_W + 2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame <= '0;
    end else if (load) begin
      // border stays zero, image lands one pixel in
      frame <= '0;
      for (int r = 0; r < IMG_H; r++) begin
        for (int c = 0; c < IMG_W; c++) begin
          frame[(r + 1) * FW + c + 1] <= img[r * IMG_W + c];
        end
      end
    end
  end

endmodule

//--- src/im2col.sv
`timescale 1ns/1ns

module im2col #(
  parameter int IMG_H = 3,
  parameter int IMG_W = 4
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          start,
  input  cnn_data_pkg::pixel_t [(IMG_H+2)*(IMG_W+2)-1:0] frame,
  output cnn_data_pkg::ram_wr_t                         wr,
  output logic                                          done
);
  import cnn_data_pkg::*;

  localparam int FW = IMG_W + 2;
  localparam int RW = (IMG_H > 1) ? $clog2(IMG_H) : 1;
  localparam int CW = (IMG_W > 1) ? $clog2(IMG_W) : 1;

  logic          busy;
  logic          active;
  logic          last;
  logic [RW-1:0] row;
  logic [CW-1:0] col;
  patch_t        patch;

  // first write goes out in the start cycle
  assign active = start || busy;
  assign last   = (row == RW'(IMG_H - 1)) && (col == CW'(IMG_W - 1));

  always_comb begin
    for (int kr = 0; kr < KSIZE; kr++) begin
      for (int kc = 0; kc < KSIZE; kc++) begin
        patch[kr * KSIZE + kc] = frame[(row + kr) * FW + col + kc];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      row  <= '0;
      col  <= '0;
    end else if (active) begin
      if (last) begin
        busy <= 1'b0;
        row  <= '0;
        col  <= '0;
      end else begin
        busy <= 1'b1;
        if (col == CW'(IMG_W - 1)) begin
          col <= '0;
          row <= row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

  assign wr   = '{we: active, addr: addr_t'(row * IMG_W + col), patch: patch};
  assign done = active && last;

endmodule

//--- src/patch_ram.sv
`timescale 1ns/1ns

module patch_ram #(
  parameter int IMG_H = 3,
  parameter int IMG_W = 4
) (
  input  logic                  clk,
  input  cnn_data_pkg::ram_wr_t wr,
  input  cnn_data_pkg::addr_t   rd_addr,
  output cnn_data_pkg::patch_t  rd_patch
);
  import cnn_data_pkg::*;

  localparam int NPOS = IMG_H * IMG_W;
  localparam int AW   = (NPOS > 1) ? $clog2(NPOS) : 1;

  patch_t mem [NPOS];

  // read data valid one cycle after the address
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr[AW-1:0]] <= wr.patch;
    end
    rd_patch <= mem[rd_addr[AW-1:0]];
  end

endmodule

//--- src/dot_engine.sv
`timescale 1ns/1ns

module dot_engine #(
  parameter int IMG_H = 3,
  parameter int IMG_W = 4
) (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      start,
  input  cnn_ctrl_pkg::layer_t                                      layer,
  output cnn_data_pkg::addr_t                                       rd_addr,
  input  cnn_data_pkg::patch_t                                      rd_patch,
  output cnn_data_pkg::acc_t [IMG_H*IMG_W*cnn_data_pkg::NUM_FILT-1:0] sums,
  output logic                                                      done
);
  import cnn_data_pkg::*;

  localparam int NPOS = IMG_H * IMG_W;
  localparam int AW   = (NPOS > 1) ? $clog2(NPOS) : 1;

  logic          busy;
  logic          issue;
  logic [AW-1:0] cnt;
  logic          vld_d;
  logic [AW-1:0] addr_d;
  acc_t          dot [NUM_FILT];

  assign issue   = start || busy;
  assign rd_addr = addr_t'(cnt);

  // valid and address follow the ram read by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      cnt    <= '0;
      vld_d  <= 1'b0;
      addr_d <= '0;
    end else begin
      vld_d  <= issue;
      addr_d <= cnt;
      if (issue) begin
        busy <= (cnt != AW'(NPOS - 1));
        cnt  <= (cnt == AW'(NPOS - 1)) ? '0 : cnt + 1'b1;
      end
    end
  end

  always_comb begin
    for (int f = 0; f < NUM_FILT; f++) begin
      dot[f] = '0;
      for (int t = 0; t < TAPS; t++) begin
        dot[f] = dot[f] + pixel_t'(rd_patch[t]) * WEIGHTS[layer][f][t];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (vld_d) begin
      for (int f = 0; f < NUM_FILT; f++) begin
        sums[addr_d * NUM_FILT + f] <= dot[f];
      end
    end
  end

  assign done = vld_d && (addr_d == AW'(NPOS - 1));

endmodule

//--- src/add_bias.sv
`timescale 1ns/1ns

module add_bias #(
  parameter int NPOS = 12
) (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic                                               start,
  input  cnn_ctrl_pkg::layer_t                               layer,
  input  cnn_data_pkg::acc_t [NPOS*cnn_data_pkg::NUM_FILT-1:0] sums,
  output cnn_data_pkg::acc_t [NPOS*cnn_data_pkg::NUM_FILT-1:0] result
);
  import cnn_data_pkg::*;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
    end else if (start) begin
      // filter index is the minor one
      for (int p = 0; p < NPOS; p++) begin
        for (int f = 0; f < NUM_FILT; f++) begin
          result[p * NUM_FILT + f] <= sums[p * NUM_FILT + f] + BIASES[layer][f];
        end
      end
    end
  end

endmodule

//--- src/cnn_layer.sv
`timescale 1ns/1ns

module cnn_layer #(
  parameter int IMG_H = 3,
  parameter int IMG_W = 4
) (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      req,
  input  cnn_ctrl_pkg::layer_t                                      layer_sel,
  input  cnn_data_pkg::pixel_t [IMG_H*IMG_W-1:0]                     img,
  output logic                                                      ack,
  output cnn_data_pkg::acc_t [IMG_H*IMG_W*cnn_data_pkg::NUM_FILT-1:0] result
);
  import cnn_data_pkg::*;
  import cnn_ctrl_pkg::*;

  logic    zpad_start;
  logic    im2c_start;
  logic    dot_start;
  logic    bias_start;
  logic    im2c_done;
  logic    dot_done;
  layer_t  layer;
  pixel_t  [(IMG_H+2)*(IMG_W+2)-1:0] frame;
  ram_wr_t wr;
  addr_t   rd_addr;
  patch_t  rd_patch;
  acc_t    [IMG_H*IMG_W*NUM_FILT-1:0] sums;

  calc_sequencer u_seq (
    .clk, .rst_n,
    .req,
    .layer_sel,
    .im2c_done,
    .dot_done,
    .zpad_start,
    .im2c_start,
    .dot_start,
    .bias_start,
    .layer,
    .ack
  );

  zero_padding #(.IMG_H(IMG_H), .IMG_W(IMG_W)) u_zpad (
    .clk, .rst_n,
    .load(zpad_start),
    .img,
    .frame
  );

  im2col #(.IMG_H(IMG_H), .IMG_W(IMG_W)) u_im2col (
    .clk, .rst_n,
    .start(im2c_start),
    .frame,
    .wr,
    .done(im2c_done)
  );

  patch_ram #(.IMG_H(IMG_H), .IMG_W(IMG_W)) u_ram (
    .clk,
    .wr,
    .rd_addr,
    .rd_patch
  );

  dot_engine #(.IMG_H(IMG_H), .IMG_W(IMG_W)) u_dot (
    .clk, .rst_n,
    .start(dot_start),
    .layer,
    .rd_addr,
    .rd_patch,
    .sums,
    .done(dot_done)
  );

  add_bias #(.NPOS(IMG_H * IMG_W)) u_bias (
    .clk, .rst_n,
    .start(bias_start),
    .layer,
    .sums,
    .result
  );

endmodule

//--- sim/cnn_layer_checker.sv
`timescale 1ns/1ns

module cnn_layer_checker #(
  parameter int IMG_H = 3,
  parameter int IMG_W = 4
) (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      req,
  input  cnn_ctrl_pkg::layer_t                                      layer_sel,
  input  cnn_data_pkg::pixel_t [IMG_H*IMG_W-1:0]                     img,
  input  logic                                                      ack,
  input  cnn_data_pkg::acc_t [IMG_H*IMG_W*cnn_data_pkg::NUM_FILT-1:0] result,
  input  int                                                        test_id,
  output int                                                        checks,
  output int                                                        errors
);
  import cnn_data_pkg::*;
  import cnn_ctrl_pkg::*;

  localparam int NRES = IMG_H * IMG_W * NUM_FILT;

  acc_t [NRES-1:0] expect_res;
  acc_t [NRES-1:0] held;
  logic            req_d = 1'b0;
  logic            ack_d = 1'b0;
  logic            pending = 1'b0;
  logic            holding = 1'b0;
  logic            after_rst = 1'b0;
  int              low_cycles = 0;
  int              cur_id = 0;
  int              n_checks = 0;
  int              n_errors = 0;
  int              test_checks = 0;
  int              test_errors = 0;

  assign checks = n_checks;
  assign errors = n_errors;

  function automatic string test_name(input int id);
    case (id)
      0: return "layer0_random";
      1: return "layer1_random";
      2: return "border_extremes";
      3: return "handshake_order";
      default: return "reset_mid_run";
    endcase
  endfunction

  // taps that fall on the border see a zero pixel
  function automatic acc_t conv_at(input int r, input int c, input int f, input layer_t l);
    int s;
    int rr;
    int cc;
    s = int'(BIASES[l][f]);
    for (int kr = 0; kr < KSIZE; kr++) begin
      for (int kc = 0; kc < KSIZE; kc++) begin
        rr = r + kr - 1;
        cc = c + kc - 1;
        if (rr >= 0 && rr < IMG_H && cc >= 0 && cc < IMG_W) begin
          s += int'(img[rr * IMG_W + cc]) * int'(WEIGHTS[l][f][kr * KSIZE + kc]);
        end
      end
    end
    return acc_t'(s);
  endfunction

  task automatic check_value(input int idx, input acc_t exp_v, input acc_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("[ERROR] %s pos %0d filter %0d: expected %0d, actual %0d",
               test_name(cur_id), idx / NUM_FILT, idx % NUM_FILT, exp_v, act_v);
    end
  endtask

  task automatic flag_protocol(input string msg);
    n_errors++;
    $display("handshake fault in %s: %s", test_name(cur_id), msg);
  endtask

  always @(posedge clk) begin
    if (test_id != cur_id) begin
      $display("test %s done: %0d checks, %0d errors", test_name(cur_id),
               n_checks - test_checks, n_errors - test_errors);
      cur_id      = test_id;
      test_checks = n_checks;
      test_errors = n_errors;
    end
    if (!rst_n) begin
      req_d      = 1'b0;
      ack_d      = 1'b0;
      pending    = 1'b0;
      holding    = 1'b0;
      after_rst  = 1'b1;
      low_cycles = 0;
    end else begin
      if (after_rst) begin
        n_checks++;
        if (ack !== 1'b0) begin
          n_errors++;
          $display("[ERROR] %s ack after reset: expected 0, actual %0b", test_name(cur_id), ack);
        end
        for (int i = 0; i < NRES; i++) begin
          check_value(i, '0, result[i]);
        end
        after_rst = 1'b0;
      end
      if (holding && result !== held) begin
        flag_protocol("result changed between ack and the next req");
        holding = 1'b0;
      end
      if (req && !req_d) begin
        for (int r = 0; r < IMG_H; r++) begin
          for (int c = 0; c < IMG_W; c++) begin
            for (int f = 0; f < NUM_FILT; f++) begin
              expect_res[(r * IMG_W + c) * NUM_FILT + f] = conv_at(r, c, f, layer_sel);
            end
          end
        end
        pending = 1'b1;
        holding = 1'b0;
      end
      low_cycles = req ? 0 : low_cycles + 1;
      if (ack && !ack_d) begin
        // ack seen now was raised from the req of the previous sample
        if (!req_d) begin
          flag_protocol("ack rose while req was low");
        end else if (!pending) begin
          flag_protocol("ack rose again with no new req");
        end else begin
          for (int i = 0; i < NRES; i++) begin
            check_value(i, expect_res[i], result[i]);
          end
        end
        pending = 1'b0;
        held    = result;
        holding = 1'b1;
      end
      if (ack && low_cycles >= 2) begin
        flag_protocol("ack still high two cycles after req dropped");
      end
      req_d = req;
      ack_d = ack;
    end
  end

endmodule

//--- sim/cnn_layer_tb.sv
`timescale 1ns/1ns

module cnn_layer_tb;
  import cnn_data_pkg::*;
  import cnn_ctrl_pkg::*;

  localparam int IMG_H   = 3;
  localparam int IMG_W   = 4;
  localparam int NPOS    = IMG_H * IMG_W;
  localparam int NUM_TXN = 31;
  // a transfer takes 2P + 4 cycles plus the handshake turnaround
  localparam int MAX_CYCLES = NUM_TXN * (2 * NPOS + 10) + 200;

  logic                     clk;
  logic                     rst_n;
  logic                     req;
  layer_t                   layer_sel;
  pixel_t [NPOS-1:0]        img;
  pixel_t [NPOS-1:0]        next_img;
  logic                     ack;
  acc_t [NPOS*NUM_FILT-1:0] result;
  int                       test_id;
  int                       checks;
  int                       errors;
  int                       cycles = 0;
  integer                   seed;

  cnn_layer #(.IMG_H(IMG_H), .IMG_W(IMG_W)) DUT (
    .clk, .rst_n, .req, .layer_sel, .img, .ack, .result
  );

  cnn_layer_checker #(.IMG_H(IMG_H), .IMG_W(IMG_W)) chk (
    .clk, .rst_n, .req, .layer_sel, .img, .ack, .result, .test_id, .checks, .errors
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles with tests unfinished", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic fill_random();
    for (int i = 0; i < NPOS; i++) begin
      next_img[i] = pixel_t'($random(seed));
    end
  endtask

  task automatic fill_const(input pixel_t v);
    for (int i = 0; i < NPOS; i++) begin
      next_img[i] = v;
    end
  endtask

  task automatic fill_corner(input int k);
    next_img = '0;
    case (k)
      0: next_img[0] = pixel_t'(127);
      1: next_img[IMG_W - 1] = pixel_t'(-128);
      2: next_img[(IMG_H - 1) * IMG_W] = pixel_t'(127);
      default: next_img[NPOS - 1] = pixel_t'(-128);
    endcase
  endtask

  // full four-phase transfer
  task automatic do_transfer(input layer_t sel);
    @(negedge clk);
    img       = next_img;
    layer_sel = sel;
    req       = 1'b1;
    while (!ack) @(negedge clk);
    req = 1'b0;
    while (ack) @(negedge clk);
  endtask

  initial begin
    seed      = 32'hf1b8;
    rst_n     = 1'b0;
    req       = 1'b0;
    layer_sel = '0;
    img       = '0;
    next_img  = '0;
    test_id   = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < 10; i++) begin
      fill_random();
      do_transfer(1'b0);
    end
    test_id = 1;
    for (int i = 0; i < 10; i++) begin
      fill_random();
      do_transfer(1'b1);
    end

    test_id = 2;
    fill_const(pixel_t'(127));
    do_transfer(1'b1);
    fill_const(pixel_t'(-128));
    do_transfer(1'b1);
    for (int k = 0; k < 4; k++) begin
      fill_corner(k);
      do_transfer(k[0]);
    end

    test_id = 3;
    for (int i = 0; i < 3; i++) begin
      fill_random();
      do_transfer(i[0]);
    end

    test_id = 4;
    fill_random();
    @(negedge clk);
    img       = next_img;
    layer_sel = 1'b1;
    req       = 1'b1;
    // dot phase runs from cycle P+2 to 2P+2 after req is sampled
    repeat (NPOS + 3) @(negedge clk);
    rst_n = 1'b0;
    req   = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    fill_random();
    do_transfer(1'b0);

    test_id = 5;
    repeat (2) @(negedge clk);
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- src.f
src/cnn_data_pkg.sv
src/cnn_ctrl_pkg.sv
src/calc_sequencer.sv
src/zero_padding.sv
src/im2col.sv
src/patch_ram.sv
src/dot_engine.sv
src/add_bias.sv
src/cnn_layer.sv
sim/cnn_layer_checker.sv
sim/cnn_layer_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cnn_layer_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
FILELIST  ?= src.f
PASS_MSG  ?= NO ERRORS

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
